//--- hdl/cordic_params.svh
`ifndef CORDIC_PARAMS_SVH
`define CORDIC_PARAMS_SVH

// angle in and sine/cosine out share one width
`define CORDIC_ANGLE_W 8
`define CORDIC_DATA_W 14
`define CORDIC_FRAC_W 12
`define CORDIC_IO_FRAC_W 6

// micro-rotations, then total edges from angle to result
`define CORDIC_STAGES 12
`define CORDIC_LATENCY 14

// 0.60725 scaled by 2^12
`define CORDIC_GAIN 2487
// pi/2 scaled by 2^12
`define CORDIC_HALF_PI 6434

`endif

//--- hdl/cordic_pkg.sv
`default_nettype none

`include "cordic_params.svh"

package cordic_pkg;

    // external fixed point, 6 fraction bits
    typedef logic signed [`CORDIC_ANGLE_W-1:0] angle_t;

    // internal fixed point, 12 fraction bits
    typedef logic signed [`CORDIC_DATA_W-1:0] data_t;

    // z holds the angle still left to rotate
    typedef struct packed {
        data_t x;
        data_t y;
        data_t z;
    } rot_state_t;

    // atan(2^-i) in internal format
    function automatic data_t atan_entry(input int i);
        data_t a;
        case (i)
            0:       a = 14'sd3217;
            1:       a = 14'sd1899;
            2:       a = 14'sd1003;
            3:       a = 14'sd509;
            4:       a = 14'sd256;
            5:       a = 14'sd128;
            6:       a = 14'sd64;
            7:       a = 14'sd32;
            8:       a = 14'sd16;
            9:       a = 14'sd8;
            10:      a = 14'sd4;
            11:      a = 14'sd2;
            // beyond 11 the angle falls under one LSB
            default: a = '0;
        endcase
        return a;
    endfunction

endpackage

`default_nettype wire

//--- hdl/cordic_bus.sv
`default_nettype none
`timescale 1ns/1ps

interface cordic_bus;
    import cordic_pkg::*;

    // path whose final x is the cosine
    rot_state_t cos_path;
    // path whose final x is the sine
    rot_state_t sin_path;
    // original angle was negative
    logic       neg;

    modport src (
        output cos_path,
        output sin_path,
        output neg
    );

    modport snk (
        input cos_path,
        input sin_path,
        input neg
    );

endinterface

`default_nettype wire

//--- hdl/angle_fold.sv
`default_nettype none
`timescale 1ns/1ps

`include "cordic_params.svh"

module angle_fold (
    input  logic               clk,
    input  logic               rst_n,
    input  cordic_pkg::angle_t angle,
    cordic_bus.src             out
);
    import cordic_pkg::*;

    localparam int SCALE_SH = `CORDIC_FRAC_W - `CORDIC_IO_FRAC_W;

    angle_t mag;
    data_t  cos_target;
    data_t  sin_target;

    // fold to the right half plane, sign restored at the output
    always_comb begin
        if (angle[`CORDIC_ANGLE_W-1]) begin
            mag = -angle;
        end else begin
            mag = angle;
        end
    end

    // widen to 12 fraction bits
    assign cos_target = data_t'({mag, {SCALE_SH{1'b0}}});

    // sin(a) = cos(pi/2 - a)
    assign sin_target = data_t'(`CORDIC_HALF_PI) - cos_target;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out.cos_path <= '0;
            out.sin_path <= '0;
            out.neg      <= 1'b0;
        end else begin
            // both paths start on the x axis, prescaled by the gain
            out.cos_path.x <= data_t'(`CORDIC_GAIN);
            out.cos_path.y <= '0;
            out.cos_path.z <= cos_target;
            out.sin_path.x <= data_t'(`CORDIC_GAIN);
            out.sin_path.y <= '0;
            out.sin_path.z <= sin_target;
            out.neg        <= angle[`CORDIC_ANGLE_W-1];
        end
    end

endmodule

`default_nettype wire

//--- hdl/cordic_stage.sv
`default_nettype none
`timescale 1ns/1ps

`include "cordic_params.svh"

module cordic_stage #(
    parameter int SHIFT = 0
) (
    input  logic   clk,
    input  logic   rst_n,
    cordic_bus.snk up,
    cordic_bus.src down
);
    import cordic_pkg::*;

    localparam data_t ATAN = atan_entry(SHIFT);

    rot_state_t cos_next;
    rot_state_t sin_next;

    // one micro-rotation, direction taken from the residual sign
    function automatic rot_state_t rotate(input rot_state_t s);
        rot_state_t r;
        data_t      x_sh;
        data_t      y_sh;
        x_sh = s.x >>> SHIFT;
        y_sh = s.y >>> SHIFT;
        if (s.z[`CORDIC_DATA_W-1]) begin
            // overshot, rotate back clockwise
            r.x = s.x + y_sh;
            r.y = s.y - x_sh;
            r.z = s.z + ATAN;
        end else begin
            r.x = s.x - y_sh;
            r.y = s.y + x_sh;
            r.z = s.z - ATAN;
        end
        return r;
    endfunction

    always_comb begin
        cos_next = rotate(up.cos_path);
        sin_next = rotate(up.sin_path);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            down.cos_path <= '0;
            down.sin_path <= '0;
            down.neg      <= 1'b0;
        end else begin
            down.cos_path <= cos_next;
            down.sin_path <= sin_next;
            // sign flag keeps pace with its angle
            down.neg      <= up.neg;
        end
    end

endmodule

`default_nettype wire

//--- hdl/cordic_pipeline.sv
`default_nettype none
`timescale 1ns/1ps

`include "cordic_params.svh"

module cordic_pipeline (
    input  logic   clk,
    input  logic   rst_n,
    cordic_bus.snk first,
    cordic_bus.src last
);

    // links between neighbouring stages only
    cordic_bus link [`CORDIC_STAGES-1] ();

    genvar i;
    generate
        for (i = 0; i < `CORDIC_STAGES; i++) begin : g_stage
            if (i == 0) begin : g_head
                cordic_stage #(
                    .SHIFT(i)
                ) u_stage (
                    .clk  (clk),
                    .rst_n(rst_n),
                    .up   (first),
                    .down (link[i])
                );
            end else if (i == `CORDIC_STAGES - 1) begin : g_tail
                cordic_stage #(
                    .SHIFT(i)
                ) u_stage (
                    .clk  (clk),
                    .rst_n(rst_n),
                    .up   (link[i-1]),
                    .down (last)
                );
            end else begin : g_mid
                cordic_stage #(
                    .SHIFT(i)
                ) u_stage (
                    .clk  (clk),
                    .rst_n(rst_n),
                    .up   (link[i-1]),
                    .down (link[i])
                );
            end
        end
    endgenerate

endmodule

`default_nettype wire

//--- hdl/result_format.sv
`default_nettype none
`timescale 1ns/1ps

`include "cordic_params.svh"

module result_format (
    input  logic               clk,
    input  logic               rst_n,
    cordic_bus.snk             in,
    output cordic_pkg::angle_t sine,
    output cordic_pkg::angle_t cosine
);
    import cordic_pkg::*;

    angle_t cos_trunc;
    angle_t sin_trunc;
    angle_t sin_signed;

    // sign plus integer bit plus 6 fraction bits, low bits just dropped
    assign cos_trunc = in.cos_path.x[`CORDIC_DATA_W-1 -: `CORDIC_ANGLE_W];
    assign sin_trunc = in.sin_path.x[`CORDIC_DATA_W-1 -: `CORDIC_ANGLE_W];

    // sine is odd, cosine even
    always_comb begin
        if (in.neg) begin
            sin_signed = -sin_trunc;
        end else begin
            sin_signed = sin_trunc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sine   <= '0;
            cosine <= '0;
        end else begin
            sine   <= sin_signed;
            cosine <= cos_trunc;
        end
    end

endmodule

`default_nettype wire

//--- hdl/cordic_sincos.sv
`default_nettype none
`timescale 1ns/1ps

module cordic_sincos (
    input  logic               clk,
    input  logic               rst_n,
    input  cordic_pkg::angle_t angle,
    output cordic_pkg::angle_t sine,
    output cordic_pkg::angle_t cosine
);

    // folded angle into the first stage
    cordic_bus head_bus ();
    // last stage into the formatter
    cordic_bus tail_bus ();

    angle_fold u_fold (
        .clk  (clk),
        .rst_n(rst_n),
        .angle(angle),
        .out  (head_bus)
    );

    cordic_pipeline u_pipeline (
        .clk  (clk),
        .rst_n(rst_n),
        .first(head_bus),
        .last (tail_bus)
    );

    result_format u_format (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (tail_bus),
        .sine  (sine),
        .cosine(cosine)
    );

endmodule

`default_nettype wire

//--- verification/cordic_props.sv
`default_nettype none
`timescale 1ns/1ps

`include "cordic_params.svh"

module cordic_props (
    input logic               clk,
    input logic               rst_n,
    input cordic_pkg::angle_t angle,
    input cordic_pkg::angle_t sine,
    input cordic_pkg::angle_t cosine
);
    import cordic_pkg::*;

    localparam angle_t MAX_ANGLE = 8'sd100;
    localparam angle_t MIN_ANGLE = -8'sd100;

    // edges seen since reset release, saturating
    int since_reset;

    // failed assertions so far
    int fail_count = 0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            since_reset <= 0;
        end else if (since_reset < `CORDIC_LATENCY) begin
            since_reset <= since_reset + 1;
        end
    end

    // pipeline still holds reset values
    a_flush_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (since_reset < `CORDIC_LATENCY) |-> (sine == '0 && cosine == '0))
        else begin
            fail_count = fail_count + 1;
            $error("sine or cosine nonzero while pipeline fills after reset");
        end

    a_sine_sign: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(angle, `CORDIC_LATENCY) >= angle_t'(0)
            && $past(angle, `CORDIC_LATENCY) <= MAX_ANGLE) |-> !sine[`CORDIC_ANGLE_W-1])
        else begin
            fail_count = fail_count + 1;
            $error("negative sine for a non-negative angle");
        end

    // cosine stays non-negative inside the supported range
    a_cosine_sign: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(angle, `CORDIC_LATENCY) >= MIN_ANGLE
            && $past(angle, `CORDIC_LATENCY) <= MAX_ANGLE) |-> !cosine[`CORDIC_ANGLE_W-1])
        else begin
            fail_count = fail_count + 1;
            $error("negative cosine for an in-range angle");
        end

endmodule

bind cordic_sincos cordic_props u_props (
    .clk   (clk),
    .rst_n (rst_n),
    .angle (angle),
    .sine  (sine),
    .cosine(cosine)
);

`default_nettype wire

//--- verification/tb_cordic_sincos.sv
`default_nettype none
`timescale 1ns/1ps

`include "cordic_params.svh"

module tb_cordic_sincos;
    import cordic_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int N_RANDOM     = 200;
    localparam int TAG_RANDOM   = -1;
    localparam int TAG_IDLE     = -2;

    logic   clk = 1'b0;
    logic   rst_n;
    angle_t angle;
    angle_t sine;
    angle_t cosine;

    // angle, then round(64*sin(angle/64)) and round(64*cos(angle/64))
    int tbl_angle [$] = '{0, 1, -1, 3, -3, 5, -5, 16, -16, 32, -32,
                          50, -50, 64, -64, 80, -80, 100, -100};
    int tbl_sin   [$] = '{0, 1, -1, 3, -3, 5, -5, 16, -16, 31, -31,
                          45, -45, 54, -54, 61, -61, 64, -64};
    int tbl_cos   [$] = '{64, 64, 64, 64, 64, 64, 64, 62, 62, 56, 56,
                          45, 45, 35, 35, 20, 20, 1, 1};

    // expected results waiting for the pipeline
    int    exp_sin_q [$];
    int    exp_cos_q [$];
    int    tag_q     [$];
    string name_q    [$];

    // table results kept for the symmetry pass
    int act_sin [int];
    int act_cos [int];

    int cycle_count = 0;

    cordic_sincos UUT (
        .clk   (clk),
        .rst_n (rst_n),
        .angle (angle),
        .sine  (sine),
        .cosine(cosine)
    );

    always #4 clk = ~clk;

    // watchdog sized from the test length
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= RESET_CYCLES + tbl_angle.size() + N_RANDOM
                           + `CORDIC_LATENCY + 20) begin
            $display("timeout: no verdict after %0d clock cycles", cycle_count);
            $display(">>> FAIL");
            $fatal(1, "timeout");
        end
    end

    function automatic int to_fixed(input real v);
        return $rtoi($floor(v + 0.5));
    endfunction

    task automatic check_value(input string name, input int expected, input int actual,
                               input int tol);
        int diff;
        diff = expected - actual;
        if (diff < 0) begin
            diff = -diff;
        end
        if (diff > tol) begin
            $display("Mismatch in %s: expected %0d, actual %0d", name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "check failed");
        end
    endtask

    // stop as soon as the bound checker has flagged anything
    task automatic check_props();
        if (UUT.u_props.fail_count != 0) begin
            $display("property checker flagged %0d assertion failures",
                     UUT.u_props.fail_count);
            $display(">>> FAIL");
            $fatal(1, "assertion failed");
        end
    endtask

    // compare the output against the entry issued LATENCY clocks ago
    task automatic score_output();
        int    exp_s;
        int    exp_c;
        int    tag;
        string name;
        check_props();
        if (tag_q.size() < `CORDIC_LATENCY) begin
            // nothing has reached the output since reset
            check_value("reset flush sine", 0, int'(sine), 0);
            check_value("reset flush cosine", 0, int'(cosine), 0);
        end else begin
            exp_s = exp_sin_q.pop_front();
            exp_c = exp_cos_q.pop_front();
            tag   = tag_q.pop_front();
            name  = name_q.pop_front();
            if (tag != TAG_IDLE) begin
                check_value({name, " sine"}, exp_s, int'(sine), 2);
                check_value({name, " cosine"}, exp_c, int'(cosine), 2);
                if (tag >= 0) begin
                    act_sin[tag] = int'(sine);
                    act_cos[tag] = int'(cosine);
                end
            end
        end
    endtask

    // one clock: score, drive the next angle, move on
    task automatic apply_angle(input int a, input int exp_s, input int exp_c, input int tag,
                               input string name);
        score_output();
        angle = angle_t'(a);
        exp_sin_q.push_back(exp_s);
        exp_cos_q.push_back(exp_c);
        tag_q.push_back(tag);
        name_q.push_back(name);
        @(posedge clk);
        #1;
    endtask

    // sine odd, cosine even
    task automatic check_symmetry();
        for (int i = 0; i < tbl_angle.size(); i++) begin
            for (int j = 0; j < tbl_angle.size(); j++) begin
                if (tbl_angle[i] > 0 && tbl_angle[j] == -tbl_angle[i]) begin
                    check_value($sformatf("symmetry sine angle %0d", tbl_angle[i]),
                                -act_sin[i], act_sin[j], 1);
                    check_value($sformatf("symmetry cosine angle %0d", tbl_angle[i]),
                                act_cos[i], act_cos[j], 0);
                end
            end
        end
    endtask

    initial begin
        int ra;
        void'($urandom(78));
        rst_n = 1'b1;
        angle = '0;
        // falling edge so the async reset takes effect
        #1;
        rst_n = 1'b0;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #1;
            check_value("reset sine", 0, int'(sine), 0);
            check_value("reset cosine", 0, int'(cosine), 0);
        end
        rst_n = 1'b1;

        // table back to back, one angle per clock
        for (int i = 0; i < tbl_angle.size(); i++) begin
            apply_angle(tbl_angle[i], tbl_sin[i], tbl_cos[i], i,
                        $sformatf("table %0d angle %0d", i, tbl_angle[i]));
        end

        for (int k = 0; k < N_RANDOM; k++) begin
            ra = int'($urandom_range(200, 0)) - 100;
            apply_angle(ra, to_fixed(64.0 * $sin(real'(ra) / 64.0)),
                        to_fixed(64.0 * $cos(real'(ra) / 64.0)), TAG_RANDOM,
                        $sformatf("random %0d angle %0d", k, ra));
        end

        // push the last results out
        repeat (`CORDIC_LATENCY) begin
            apply_angle(0, 0, 0, TAG_IDLE, "idle");
        end

        check_symmetry();

        if (UUT.u_props.fail_count != 0) begin
            $display("property checker flagged %0d assertion failures",
                     UUT.u_props.fail_count);
            $display(">>> FAIL");
            $fatal(1, "assertion failed");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+hdl
hdl/cordic_pkg.sv
hdl/cordic_bus.sv
hdl/angle_fold.sv
hdl/cordic_stage.sv
hdl/cordic_pipeline.sv
hdl/result_format.sv
hdl/cordic_sincos.sv
verification/cordic_props.sv
verification/tb_cordic_sincos.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the CORDIC sine/cosine testbench with Verilator.
# The exit status is the simulator's: any $fatal makes it nonzero.

set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
SIM_EXE=sim_cordic

verilator --binary --timing --assert \
    -f src.f \
    --top-module tb_cordic_sincos \
    -Mdir "${BUILD_DIR}" \
    -o "${SIM_EXE}"

"./${BUILD_DIR}/${SIM_EXE}"

echo "simulation finished"
